// ==== rv_exec_defs.svh ====
`ifndef RV_EXEC_DEFS_SVH
`define RV_EXEC_DEFS_SVH

// datapath and address width
`define XLEN 32

// issue queue entries, power of two, 2 or more
`define IQ_DEPTH 4

// pc bits carried with a btb update
`define BTB_PC_W 25

`endif

// ==== rv_exec_pkg.sv ====
`include "rv_exec_defs.svh"

package rv_exec_pkg;

	typedef enum logic [3:0] {
		cls_lui,
		cls_auipc,
		cls_jal,
		cls_jalr,
		cls_branch,
		cls_load,
		cls_store,
		cls_op_imm,
		cls_op_reg,
		cls_illegal
	} op_class_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_xor,
		alu_or,
		alu_srl,
		alu_sra,
		alu_sll,
		alu_slt,
		alu_sltu
	} alu_op_e;

	typedef struct packed {
		logic [31:0]      instr;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] npc_pred; // predicted by fetch
		logic [`XLEN-1:0] src1;
		logic [`XLEN-1:0] src2;
	} fetch_pkt_t;

	typedef struct packed {
		op_class_e        op_class;
		alu_op_e          alu_op;
		logic [2:0]       funct3;
		logic [4:0]       rd;
		logic             reg_wen;
		logic [`XLEN-1:0] imm;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] npc_pred;
		logic [`XLEN-1:0] src1;
		logic [`XLEN-1:0] src2;
	} dec_op_t;

	typedef struct packed {
		logic [4:0]       rd;
		logic             reg_wen;
		logic [`XLEN-1:0] value;
	} exe_result_t;

	typedef struct packed {
		logic             ren;
		logic             wen;
		logic [`XLEN-1:0] addr;
		logic [`XLEN-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [`XLEN-1:0]    target;
		logic [`BTB_PC_W-1:0] btb_pc;
		logic                btb_update;
	} redirect_t;

endpackage

// ==== rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_decode import rv_exec_pkg::*; (
	input  logic       clock,
	input  logic       rst_n,
	input  logic       fetch_valid,
	input  fetch_pkt_t fetch_pkt,
	input  logic       flush,
	output logic       dec_valid,
	output dec_op_t    dec_op
);

	logic [31:0]      instr;
	logic [2:0]       funct3;
	logic [4:0]       rd;
	logic             bit30;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_s;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;
	logic [`XLEN-1:0] imm;
	op_class_e        op_class;
	alu_op_e          alu_op;
	logic             writes_rd;
	logic             valid_q;

	assign instr  = fetch_pkt.instr;
	assign funct3 = instr[14:12];
	assign rd     = instr[11:7];
	assign bit30  = instr[30];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		op_class  = cls_illegal;
		imm       = '0;
		writes_rd = 1'b0;
		case (instr[6:0])
			7'b0110111: begin
				op_class  = cls_lui;
				imm       = imm_u;
				writes_rd = 1'b1;
			end
			7'b0010111: begin
				op_class  = cls_auipc;
				imm       = imm_u;
				writes_rd = 1'b1;
			end
			7'b1101111: begin
				op_class  = cls_jal;
				imm       = imm_j;
				writes_rd = 1'b1;
			end
			7'b1100111: begin
				op_class  = cls_jalr;
				imm       = imm_i;
				writes_rd = 1'b1;
			end
			7'b1100011: begin
				op_class = cls_branch;
				imm      = imm_b;
			end
			7'b0000011: begin
				op_class  = cls_load;
				imm       = imm_i;
				writes_rd = 1'b1;
			end
			7'b0100011: begin
				op_class = cls_store;
				imm      = imm_s;
			end
			7'b0010011: begin
				op_class  = cls_op_imm;
				imm       = imm_i; // shamt sits in imm[4:0]
				writes_rd = 1'b1;
			end
			7'b0110011: begin
				op_class  = cls_op_reg;
				writes_rd = 1'b1;
			end
			default: ;
		endcase
	end

	// loads, stores, jumps and branches all use the adder
	always_comb begin
		alu_op = alu_add;
		if (op_class == cls_op_imm || op_class == cls_op_reg) begin
			case (funct3)
				3'b000: alu_op = (op_class == cls_op_reg && bit30) ? alu_sub : alu_add;
				3'b001: alu_op = alu_sll;
				3'b010: alu_op = alu_slt;
				3'b011: alu_op = alu_sltu;
				3'b100: alu_op = alu_xor;
				3'b101: alu_op = bit30 ? alu_sra : alu_srl;
				3'b110: alu_op = alu_or;
				default: alu_op = alu_and;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= fetch_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_valid) begin
			dec_op.op_class <= op_class;
			dec_op.alu_op   <= alu_op;
			dec_op.funct3   <= funct3;
			dec_op.rd       <= rd;
			dec_op.reg_wen  <= writes_rd & (rd != 5'd0); // x0 never written
			dec_op.imm      <= imm;
			dec_op.pc       <= fetch_pkt.pc;
			dec_op.npc_pred <= fetch_pkt.npc_pred;
			dec_op.src1     <= fetch_pkt.src1;
			dec_op.src2     <= fetch_pkt.src2;
		end
	end

	assign dec_valid = valid_q & ~flush; // held op is wrong path

endmodule

// ==== rv_issue_queue.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_issue_queue import rv_exec_pkg::*; (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic                        push,
	input  dec_op_t                     push_op,
	input  logic                        flush,
	output logic                        issue_valid,
	output dec_op_t                     issue_op,
	output logic [$clog2(`IQ_DEPTH):0]  count
);

	localparam int PTR_W = $clog2(`IQ_DEPTH);

	dec_op_t          entries [`IQ_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             pop;
	logic             do_push;

	assign pop     = (count != '0); // head leaves every cycle
	assign do_push = push & ~flush;

	assign issue_valid = pop;
	assign issue_op    = entries[rd_ptr];

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			entries[wr_ptr] <= push_op;
		end
	end

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_execute import rv_exec_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        issue_valid,
	input  dec_op_t     issue_op,
	output logic        result_valid,
	output exe_result_t result,
	output logic        mem_valid,
	output mem_req_t    mem_req,
	output logic        redirect_valid,
	output redirect_t   redirect
);

	logic             accept;
	logic [`XLEN-1:0] lhs;
	logic [`XLEN-1:0] rhs;
	logic [`XLEN-1:0] sum;
	logic [`XLEN:0]   diff;
	logic             lt;
	logic             ltu;
	logic [`XLEN-1:0] alu_val;
	logic [`XLEN:0]   cmp_diff;
	logic             br_lt;
	logic             br_ltu;
	logic             br_taken;
	logic             is_jump;
	logic             take_target;
	logic [`XLEN-1:0] snpc;
	logic [`XLEN-1:0] npc_actual;
	logic [`XLEN-1:0] wb_val;
	logic             wb_en;
	logic             mem_en;
	logic             mispredict;
	logic             need_btb;

	// redirect in flight, this op is wrong path
	assign accept = issue_valid & ~redirect_valid;

	always_comb begin
		case (issue_op.op_class)
			cls_auipc, cls_jal, cls_branch: lhs = issue_op.pc;
			cls_lui: lhs = '0;
			default: lhs = issue_op.src1; // jalr, mem and alu ops
		endcase
	end

	assign rhs = (issue_op.op_class == cls_op_reg) ? issue_op.src2 : issue_op.imm;

	assign sum  = lhs + rhs;
	assign diff = {1'b0, lhs} - {1'b0, rhs}; // msb is borrow
	assign lt   = (lhs[`XLEN-1] != rhs[`XLEN-1]) ? lhs[`XLEN-1] : diff[`XLEN-1];
	assign ltu  = diff[`XLEN];

	always_comb begin
		case (issue_op.alu_op)
			alu_add:  alu_val = sum;
			alu_sub:  alu_val = diff[`XLEN-1:0];
			alu_and:  alu_val = lhs & rhs;
			alu_xor:  alu_val = lhs ^ rhs;
			alu_or:   alu_val = lhs | rhs;
			alu_srl:  alu_val = lhs >> rhs[4:0];
			alu_sra:  alu_val = $signed(lhs) >>> rhs[4:0];
			alu_sll:  alu_val = lhs << rhs[4:0];
			alu_slt:  alu_val = {{(`XLEN-1){1'b0}}, lt};
			alu_sltu: alu_val = {{(`XLEN-1){1'b0}}, ltu};
			default:  alu_val = '0;
		endcase
	end

	// branch condition on the register operands
	assign cmp_diff = {1'b0, issue_op.src1} - {1'b0, issue_op.src2};
	assign br_lt    = (issue_op.src1[`XLEN-1] != issue_op.src2[`XLEN-1]) ?
		issue_op.src1[`XLEN-1] : cmp_diff[`XLEN-1];
	assign br_ltu   = cmp_diff[`XLEN];

	always_comb begin
		case (issue_op.funct3)
			3'b000:  br_taken = (issue_op.src1 == issue_op.src2);
			3'b001:  br_taken = (issue_op.src1 != issue_op.src2);
			3'b100:  br_taken = br_lt;
			3'b101:  br_taken = ~br_lt;
			3'b110:  br_taken = br_ltu;
			3'b111:  br_taken = ~br_ltu;
			default: br_taken = 1'b0;
		endcase
	end

	assign is_jump     = (issue_op.op_class == cls_jal) || (issue_op.op_class == cls_jalr);
	assign take_target = is_jump || (issue_op.op_class == cls_branch && br_taken);
	assign snpc        = issue_op.pc + `XLEN'd4;
	assign npc_actual  = take_target ? sum : snpc;
	assign wb_val      = is_jump ? snpc : alu_val; // link address

	assign wb_en = accept & issue_op.reg_wen
		& (issue_op.op_class != cls_store)
		& (issue_op.op_class != cls_branch)
		& (issue_op.op_class != cls_illegal);
	assign mem_en = accept
		& ((issue_op.op_class == cls_load) || (issue_op.op_class == cls_store));
	assign mispredict = accept & (npc_actual != issue_op.npc_pred);

	// only jal and backward branches train the btb
	assign need_btb = (issue_op.op_class == cls_jal)
		|| (issue_op.op_class == cls_branch && issue_op.imm[`XLEN-1]);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			result_valid   <= 1'b0;
			mem_valid      <= 1'b0;
			redirect_valid <= 1'b0;
		end else begin
			result_valid   <= wb_en;
			mem_valid      <= mem_en;
			redirect_valid <= mispredict;
		end
	end

	always_ff @(posedge clock) begin
		if (wb_en) begin
			result.rd      <= issue_op.rd;
			result.reg_wen <= issue_op.reg_wen;
			result.value   <= wb_val;
		end
		if (mem_en) begin
			mem_req.ren   <= (issue_op.op_class == cls_load);
			mem_req.wen   <= (issue_op.op_class == cls_store);
			mem_req.addr  <= sum;
			mem_req.wdata <= issue_op.src2;
		end
		if (mispredict) begin
			redirect.target     <= npc_actual;
			redirect.btb_pc     <= issue_op.pc[`BTB_PC_W-1:0];
			redirect.btb_update <= need_btb;
		end
	end

endmodule

// ==== rv_exec_top.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_exec_top import rv_exec_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        fetch_valid,
	input  fetch_pkt_t  fetch_pkt,
	output logic        result_valid,
	output exe_result_t result,
	output logic        mem_valid,
	output mem_req_t    mem_req,
	output logic        redirect_valid,
	output redirect_t   redirect
);

	logic    dec_valid;
	dec_op_t dec_op;
	logic    issue_valid;
	dec_op_t issue_op;

	rv_decode u_decode (
		.clock       (clock),
		.rst_n       (rst_n),
		.fetch_valid (fetch_valid),
		.fetch_pkt   (fetch_pkt),
		.flush       (redirect_valid),
		.dec_valid   (dec_valid),
		.dec_op      (dec_op)
	);

	rv_issue_queue u_queue (
		.clock       (clock),
		.rst_n       (rst_n),
		.push        (dec_valid),
		.push_op     (dec_op),
		.flush       (redirect_valid),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.count       ()
	);

	rv_execute u_execute (
		.clock          (clock),
		.rst_n          (rst_n),
		.issue_valid    (issue_valid),
		.issue_op       (issue_op),
		.result_valid   (result_valid),
		.result         (result),
		.mem_valid      (mem_valid),
		.mem_req        (mem_req),
		.redirect_valid (redirect_valid),
		.redirect       (redirect)
	);

endmodule

// ==== tb_rv_exec_top.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module tb_rv_exec_top import rv_exec_pkg::*; ();

	typedef struct packed {
		op_class_e   cls;
		logic [2:0]  f3;
		logic        b30;
		logic [4:0]  rd;
		logic [31:0] imm;
		logic [31:0] pc;
		logic [31:0] npc_pred;
		logic [31:0] src1;
		logic [31:0] src2;
	} stim_t;

	typedef struct packed {
		logic [31:0] cyc;  // cycle the output is due
		logic [65:0] data;
	} exp_t;

	logic        clock;
	logic        rst_n;
	logic        fetch_valid;
	fetch_pkt_t  fetch_pkt;
	logic        result_valid;
	exe_result_t result;
	logic        mem_valid;
	mem_req_t    mem_req;
	logic        redirect_valid;
	redirect_t   redirect;

	logic [31:0] lfsr;
	logic [31:0] cyc = '0;
	logic [31:0] squash_end = '0; // last strobe cycle lost to a flush
	exp_t        exp_q [3][$];    // result, memory, redirect
	string       chan [3] = '{"result", "memory", "redirect"};
	int          mismatches = 0;
	int          unexpected = 0;
	int          missing = 0;
	int          timeouts = 0;

	rv_exec_top dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) cyc <= cyc + 1;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [2:0] br_f3(input int k);
		return (k % 6 < 2) ? 3'(k % 6) : 3'(k % 6 + 2); // skip 010 and 011
	endfunction

	function automatic int pending();
		return exp_q[0].size() + exp_q[1].size() + exp_q[2].size();
	endfunction

	function automatic logic [31:0] encode_instr(input stim_t s);
		case (s.cls)
			cls_lui:    return {s.imm[31:12], s.rd, 7'b0110111};
			cls_auipc:  return {s.imm[31:12], s.rd, 7'b0010111};
			cls_jal:    return {s.imm[20], s.imm[10:1], s.imm[11], s.imm[19:12], s.rd, 7'b1101111};
			cls_jalr:   return {s.imm[11:0], 5'd1, 3'b000, s.rd, 7'b1100111};
			cls_branch: return {s.imm[12], s.imm[10:5], 5'd2, 5'd1, s.f3, s.imm[4:1], s.imm[11],
				7'b1100011};
			cls_load:   return {s.imm[11:0], 5'd1, 3'b010, s.rd, 7'b0000011};
			cls_store:  return {s.imm[11:5], 5'd2, 5'd1, 3'b010, s.imm[4:0], 7'b0100011};
			cls_op_imm: return {s.imm[11:0], 5'd1, s.f3, s.rd, 7'b0010011};
			cls_op_reg: return {1'b0, s.b30, 5'd0, 5'd2, 5'd1, s.f3, s.rd, 7'b0110011};
			default:    return 32'hffff_ffff; // unknown major opcode
		endcase
	endfunction

	task automatic evaluate(input stim_t s, output logic [31:0] sum, output logic [31:0] wb,
			output logic [31:0] next);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] alu;
		logic        taken;
		logic        jump;
		a = s.src1;
		if (s.cls == cls_auipc || s.cls == cls_jal || s.cls == cls_branch)
			a = s.pc;
		if (s.cls == cls_lui)
			a = '0;
		b = (s.cls == cls_op_reg) ? s.src2 : s.imm;
		sum = a + b;
		alu = sum;
		if (s.cls == cls_op_imm || s.cls == cls_op_reg) begin
			case (s.f3)
				3'b000: alu = (s.cls == cls_op_reg && s.b30) ? a - b : a + b;
				3'b001: alu = a << b[4:0];
				3'b010: alu = {31'b0, $signed(a) < $signed(b)};
				3'b011: alu = {31'b0, a < b};
				3'b100: alu = a ^ b;
				3'b101: begin
					if (s.b30)
						alu = $signed(a) >>> b[4:0];
					else
						alu = a >> b[4:0];
				end
				3'b110: alu = a | b;
				default: alu = a & b;
			endcase
		end
		case (s.f3)
			3'b000: taken = (s.src1 == s.src2);
			3'b001: taken = (s.src1 != s.src2);
			3'b100: taken = ($signed(s.src1) < $signed(s.src2));
			3'b101: taken = ($signed(s.src1) >= $signed(s.src2));
			3'b110: taken = (s.src1 < s.src2);
			3'b111: taken = (s.src1 >= s.src2);
			default: taken = 1'b0;
		endcase
		jump = (s.cls == cls_jal || s.cls == cls_jalr);
		next = (jump || (s.cls == cls_branch && taken)) ? sum : s.pc + 32'd4;
		wb   = jump ? s.pc + 32'd4 : alu;
	endtask

	task automatic make_op(input op_class_e cls, input logic [2:0] f3, input logic b30,
			input logic miss, output stim_t s);
		logic [31:0] t;
		logic [31:0] sum;
		logic [31:0] wb;
		logic [31:0] next;
		t      = rand_bits(20);
		s.cls  = cls;
		s.f3   = f3;
		s.b30  = b30;
		s.rd   = 5'(rand_bits(5));
		s.pc   = rand_bits(30) << 2;
		s.src1 = rand_bits(32);
		s.src2 = rand_bits(32);
		if (s.rd == 5'd0)
			s.rd = 5'd9;
		case (cls)
			cls_lui, cls_auipc:      s.imm = {t[19:0], 12'b0};
			cls_jal:                 s.imm = {{11{t[19]}}, t[19:0], 1'b0};
			cls_branch:              s.imm = {{19{t[11]}}, t[11:0], 1'b0};
			cls_op_reg, cls_illegal: s.imm = '0;
			default:                 s.imm = {{20{t[11]}}, t[11:0]};
		endcase
		if (cls == cls_op_imm && f3[1:0] == 2'b01)
			s.imm = {21'b0, b30, 5'b0, t[4:0]}; // shift, funct7 carries bit 30
		else if (cls == cls_op_imm)
			s.b30 = s.imm[10];
		if (cls == cls_branch && t[12])
			s.src2 = s.src1; // equal operands now and then
		s.npc_pred = '0;
		evaluate(s, sum, wb, next);
		s.npc_pred = miss ? next ^ 32'h10 : next;
	endtask

	task automatic send_op(input stim_t s);
		logic [31:0] sum;
		logic [31:0] wb;
		logic [31:0] next;
		logic [31:0] now;
		exp_t        e;
		@(posedge clock);
		fetch_valid <= 1'b1;
		fetch_pkt   <= '{instr: encode_instr(s), pc: s.pc, npc_pred: s.npc_pred,
			src1: s.src1, src2: s.src2};
		now = cyc + 1;
		evaluate(s, sum, wb, next);
		if (now > squash_end) begin
			e.cyc = now + 3;
			if (s.rd != 5'd0 && s.cls != cls_store && s.cls != cls_branch
					&& s.cls != cls_illegal) begin
				e.data = 66'({s.rd, 1'b1, wb});
				exp_q[0].push_back(e);
			end
			if (s.cls == cls_load || s.cls == cls_store) begin
				e.data = 66'({s.cls == cls_load, s.cls == cls_store, sum, s.src2});
				exp_q[1].push_back(e);
			end
			if (next != s.npc_pred) begin
				e.data = 66'({next, s.pc[`BTB_PC_W-1:0],
					s.cls == cls_jal || (s.cls == cls_branch && s.imm[31])});
				exp_q[2].push_back(e);
				squash_end = now + 2; // the next two strobes are wrong path
			end
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		@(posedge clock);
		fetch_valid <= 1'b0;
		while (pending() > 0 && n < 40) begin
			@(posedge clock);
			n++;
		end
		assert (pending() == 0) else begin
			timeouts++;
			$display("timed out after %0d cycles waiting for expected outputs", n);
		end
	endtask

	always @(negedge clock) begin
		logic [2:0][65:0] got;
		logic [2:0]       vld;
		exp_t             e;
		got = {66'(redirect), 66'(mem_req), 66'(result)};
		vld = {redirect_valid, mem_valid, result_valid};
		if (rst_n) begin
			for (int ch = 0; ch < 3; ch++) begin
				if (vld[ch]) begin
					assert (exp_q[ch].size() > 0) else begin
						unexpected++;
						$display("unexpected %s output at %0t", chan[ch], $time);
					end
					if (exp_q[ch].size() > 0) begin
						e = exp_q[ch].pop_front();
						assert (e.cyc == cyc && e.data == got[ch]) else begin
							mismatches++;
							$display("MISMATCH at %0t: %s got %h in cycle %0d, expected %h in cycle %0d",
								$time, chan[ch], got[ch], cyc, e.data, e.cyc);
						end
					end
				end
				if (exp_q[ch].size() > 0) begin
					assert (exp_q[ch][0].cyc > cyc) else begin
						missing++;
						$display("%s output due in cycle %0d never appeared", chan[ch],
							exp_q[ch][0].cyc);
						void'(exp_q[ch].pop_front());
					end
				end
			end
		end
	end

	initial begin
		stim_t     s;
		op_class_e c;
		int        errors;
		rst_n       = 1'b0;
		fetch_valid = 1'b0;
		fetch_pkt   = '0;
		lfsr        = 32'h89df_18b6;
		repeat (16) @(posedge clock);
		assert (!result_valid && !mem_valid && !redirect_valid) else begin
			unexpected++;
			$display("outputs are not low during reset");
		end
		rst_n <= 1'b1;

		for (int k = 0; k < 64; k++) begin
			make_op(k[4] ? cls_op_reg : cls_op_imm, k[2:0], k[3], 1'b0, s);
			send_op(s);
		end
		make_op(cls_op_reg, 3'b000, 1'b0, 1'b0, s);
		s.rd = 5'd0; // x0 write, no result
		send_op(s);
		make_op(cls_lui, 3'b000, 1'b0, 1'b0, s);
		send_op(s);
		make_op(cls_auipc, 3'b000, 1'b0, 1'b0, s);
		send_op(s);
		make_op(cls_illegal, 3'b000, 1'b0, 1'b0, s);
		send_op(s);
		wait_drain();

		// single strobes into an empty queue
		for (int k = 0; k < 4; k++) begin
			make_op(k[0] ? cls_auipc : cls_op_imm, 3'(rand_bits(3)), 1'(rand_bits(1)), 1'b0, s);
			send_op(s);
			wait_drain();
		end

		for (int k = 0; k < 8; k++) begin
			make_op(k[0] ? cls_store : cls_load, 3'b010, 1'b0, 1'b0, s);
			send_op(s);
		end
		wait_drain();

		// well predicted control flow
		for (int k = 0; k < 20; k++) begin
			if (k < 12)
				make_op(cls_branch, br_f3(k), 1'b0, 1'b0, s);
			else
				make_op(k[0] ? cls_jalr : cls_jal, 3'b000, 1'b0, 1'b0, s);
			send_op(s);
		end
		wait_drain();

		// mispredicts with a strobe on every following cycle
		for (int k = 0; k < 12; k++) begin
			c = (k % 3 == 0) ? cls_jal : ((k % 3 == 1) ? cls_jalr : cls_branch);
			make_op(c, (c == cls_branch) ? br_f3(k) : 3'b000, 1'b0, 1'b1, s);
			send_op(s);
			for (int j = 0; j < 5; j++) begin
				make_op(cls_op_reg, 3'(rand_bits(3)), 1'(rand_bits(1)), 1'b0, s);
				send_op(s);
			end
			wait_drain();
		end

		errors = mismatches + unexpected + missing + timeouts;
		$display("errors: %0d mismatch, %0d unexpected, %0d missing, %0d timeout",
			mismatches, unexpected, missing, timeouts);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== rv_exec_top.f ====
+incdir+.
rv_exec_pkg.sv
rv_decode.sv
rv_issue_queue.sv
rv_execute.sv
rv_exec_top.sv
tb_rv_exec_top.sv

// ==== Bender.yml ====
package:
  name: rv_exec

sources:
  - include_dirs:
      - .
    files:
      - rv_exec_pkg.sv
      - rv_decode.sv
      - rv_issue_queue.sv
      - rv_execute.sv
      - rv_exec_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_exec_top.sv
